//--- bench/tb_isa_model.svh
// reference interpreter for the toy ISA, producing the expected ordered store stream

// runs the program in imem from RESET_PC until halt
task automatic run_model(output bit reached_halt);
    word_t  regs [NUM_REGS];
    word_t  mem [DMEM_WORDS];
    word_t  pc;
    word_t  pc_next;
    word_t  a;
    word_t  b;
    word_t  ext;
    word_t  res;
    instr_u w;
    logic   wr;
    int     steps;

    for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] = dmem_fill(i);
    end
    pc = RESET_PC;
    steps = 0;
    reached_halt = 1'b0;
    while (!reached_halt && steps < MODEL_STEPS) begin
        w = imem[imem_index(pc)];
        a = regs[w.r.rs1];
        // r-type reads rs2, every other format reads the rd slot
        b = (w.r.opcode == OP_ALU) ? regs[w.r.rs2] : regs[w.i.rd];
        ext = {{12{w.i.imm[19]}}, w.i.imm};
        res = '0;
        wr = 1'b0;
        pc_next = pc + 32'd4;
        case (w.r.opcode)
            OP_ALU: begin
                wr = 1'b1;
                case (w.r.alu_op)
                    ALU_SUB: res = a - b;
                    ALU_AND: res = a & b;
                    ALU_OR:  res = a | b;
                    ALU_XOR: res = a ^ b;
                    ALU_SLT: res = {31'b0, $signed(a) < $signed(b)};
                    default: res = a + b;
                endcase
            end
            OP_ADDI: begin
                wr = 1'b1;
                res = a + ext;
            end
            OP_LW: begin
                wr = 1'b1;
                res = mem[dmem_index(a + ext)];
            end
            OP_SW: begin
                mem[dmem_index(a + ext)] = b;
                exp_addr.push_back(a + ext);
                exp_data.push_back(b);
            end
            OP_BEQ: if (a == b) pc_next = pc + ext;
            OP_BNE: if (a != b) pc_next = pc + ext;
            OP_JAL: begin
                wr = 1'b1;
                res = pc + 32'd4;
                pc_next = pc + ext;
            end
            default: reached_halt = 1'b1;
        endcase
        // r0 stays zero
        if (wr && w.r.rd != REG_ZERO) begin
            regs[w.r.rd] = res;
        end
        pc = pc_next;
        steps++;
    end
endtask

//--- bench/tb_sc_datapath.sv
// testbench for sc_datapath: clock, reset, memory responders, program generator and checks
`timescale 1ns/1ps
`default_nettype none

module tb_sc_datapath;
    import core_pkg::*;

    localparam word_t RESET_PC    = 32'h0000_0040;
    localparam int    IMEM_WORDS  = 256;
    localparam int    DMEM_WORDS  = 64;
    localparam int    BODY_LEN    = 64;
    localparam int    MODEL_STEPS = 4096;
    localparam int    HALT_LIMIT  = 20000;

    logic  CLK;
    logic  nrst;
    logic  imem_ren;
    word_t imem_addr;
    logic  ihit;
    word_t imem_load;
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_addr;
    word_t dmem_store;
    logic  dhit;
    word_t dmem_load;
    logic  halt;

    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    store_count;
    int    icnt;
    int    dcnt;
    int    cycles;
    bit    model_ok;

    sc_datapath #(
        .RESET_PC (RESET_PC)
    ) dut (
        .CLK        (CLK),
        .nrst       (nrst),
        .imem_ren   (imem_ren),
        .imem_addr  (imem_addr),
        .ihit       (ihit),
        .imem_load  (imem_load),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .dhit       (dhit),
        .dmem_load  (dmem_load),
        .halt       (halt)
    );

    function automatic logic [7:0] imem_index(word_t a);
        word_t off;
        off = a - RESET_PC;
        return off[9:2];
    endfunction

    function automatic logic [5:0] dmem_index(word_t a);
        return a[7:2];
    endfunction

    // initial data contents depend on every address bit
    function automatic word_t dmem_fill(int idx);
        word_t k;
        k = word_t'(idx);
        return (k * 32'h9e37_79b9) ^ {k[15:0], ~k[15:0]};
    endfunction

    function automatic word_t encode_r(alu_op_t f, reg_idx_t d, reg_idx_t s1, reg_idx_t s2);
        instr_u w;
        w = '0;
        w.r.opcode = OP_ALU;
        w.r.rd = d;
        w.r.rs1 = s1;
        w.r.rs2 = s2;
        w.r.alu_op = f;
        return w;
    endfunction

    function automatic word_t encode_i(opcode_t op, reg_idx_t d, reg_idx_t s1, logic [19:0] imm);
        instr_u w;
        w = '0;
        w.i.opcode = op;
        w.i.rd = d;
        w.i.rs1 = s1;
        w.i.imm = imm;
        return w;
    endfunction

    task automatic check_equal(word_t got, word_t want, string what);
        if (got !== want) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
            $display(">>> FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic abort_run(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    `include "tb_isa_model.svh"

    // random body with forward-only control flow, then a store of every register and halt
    task automatic gen_program();
        int       kind;
        int       span;
        reg_idx_t d;
        reg_idx_t s1;
        reg_idx_t s2;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = encode_i(OP_HALT, REG_ZERO, REG_ZERO, 20'd0);
        end
        for (int p = 0; p < BODY_LEN; p++) begin
            kind = $urandom % 10;
            d = reg_idx_t'($urandom);
            s1 = reg_idx_t'($urandom);
            s2 = reg_idx_t'($urandom);
            span = 1 + $urandom % 4;
            if (span > BODY_LEN - p) begin
                span = BODY_LEN - p;
            end
            case (kind)
                0, 1, 2: imem[p] = encode_r(alu_op_t'($urandom % 6), d, s1, s2);
                3, 4:    imem[p] = encode_i(OP_ADDI, d, s1, 20'($urandom));
                5:       imem[p] = encode_i(OP_LW, d, s1, 20'($urandom % 256));
                6:       imem[p] = encode_i(OP_SW, d, s1, 20'($urandom % 256));
                7:       imem[p] = encode_i(OP_BEQ, d, s1, 20'(4 * span));
                8:       imem[p] = encode_i(OP_BNE, d, s1, 20'(4 * span));
                default: imem[p] = encode_i(OP_JAL, d, REG_ZERO, 20'(4 * span));
            endcase
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            imem[BODY_LEN + r] = encode_i(OP_SW, reg_idx_t'(r), REG_ZERO, 20'(256 + 4 * r));
        end
        imem[BODY_LEN + NUM_REGS] = encode_i(OP_HALT, REG_ZERO, REG_ZERO, 20'd0);
    endtask

    // compares one completed store against the model's next one
    task automatic record_store();
        if (store_count >= exp_addr.size()) begin
            abort_run("DUT stored more words than the model expects");
        end else begin
            check_equal(dmem_addr, exp_addr[store_count], "store address");
            check_equal(dmem_store, exp_data[store_count], "store data");
            store_count++;
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // instruction memory answers in 1 to 3 cycles
    always @(posedge CLK) begin
        if (!nrst) begin
            ihit <= 1'b0;
            icnt = 0;
        end else if (ihit) begin
            ihit <= 1'b0;
        end else if (imem_ren) begin
            if (icnt == 0) begin
                icnt = 1 + $urandom % 3;
            end
            icnt--;
            if (icnt == 0) begin
                ihit <= 1'b1;
                imem_load <= imem[imem_index(imem_addr)];
            end
        end
    end

    // data memory answers in 1 to 4 cycles
    always @(posedge CLK) begin
        if (!nrst) begin
            dhit <= 1'b0;
            dcnt = 0;
            store_count = 0;
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] = dmem_fill(i);
            end
        end else if (dhit) begin
            dhit <= 1'b0;
        end else if (dmem_ren || dmem_wen) begin
            if (halt) begin
                abort_run("data memory accessed after halt");
            end
            if (dcnt == 0) begin
                dcnt = 1 + $urandom % 4;
            end
            dcnt--;
            if (dcnt == 0) begin
                dhit <= 1'b1;
                if (dmem_wen) begin
                    record_store();
                    dmem[dmem_index(dmem_addr)] = dmem_store;
                end else begin
                    dmem_load <= dmem[dmem_index(dmem_addr)];
                end
            end
        end
    end

    initial begin
        nrst = 1'b0;
        ihit = 1'b0;
        imem_load = '0;
        dhit = 1'b0;
        dmem_load = '0;
        void'($urandom(32'h8417_63e9));
        gen_program();
        run_model(model_ok);
        if (!model_ok) begin
            abort_run("reference model never reached halt");
        end

        repeat (8) @(posedge CLK);
        check_equal(word_t'(imem_ren), 32'd0, "imem_ren in reset");
        check_equal(word_t'(dmem_ren), 32'd0, "dmem_ren in reset");
        check_equal(word_t'(dmem_wen), 32'd0, "dmem_wen in reset");
        check_equal(word_t'(halt), 32'd0, "halt in reset");
        nrst <= 1'b1;
        @(negedge CLK);
        check_equal(word_t'(imem_ren), 32'd0, "imem_ren after reset");
        check_equal(word_t'(dmem_ren), 32'd0, "dmem_ren after reset");
        check_equal(word_t'(dmem_wen), 32'd0, "dmem_wen after reset");
        check_equal(word_t'(halt), 32'd0, "halt after reset");

        cycles = 0;
        while (!imem_ren) begin
            @(negedge CLK);
            cycles++;
            if (cycles > 16) begin
                abort_run("timeout waiting for the first instruction fetch");
            end
        end
        check_equal(imem_addr, RESET_PC, "first fetch address");

        cycles = 0;
        while (!halt) begin
            @(negedge CLK);
            cycles++;
            if (cycles > HALT_LIMIT) begin
                abort_run("timeout waiting for halt");
            end
        end
        check_equal(word_t'(store_count), word_t'(exp_addr.size()), "store count at halt");

        // the data responder flags any access in this quiet window
        repeat (20) @(negedge CLK);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile and run the sc_datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_sc_datapath \
    -f src.f \
    -o tb_sc_datapath

./obj_dir/tb_sc_datapath 2>&1 | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

//--- source/core_pkg.sv
// ISA types for the scalar core: words, register indices, opcodes, ALU ops, instruction formats
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    localparam int       NUM_REGS    = 16;
    localparam reg_idx_t REG_ZERO    = 4'd0;
    localparam word_t    INSTR_BYTES = 32'd4;

    // instruction classes in bits [31:28]
    // branch and jal targets are pc + imm, imm being a byte offset
    typedef enum logic [3:0] {
        OP_ALU  = 4'h0,
        OP_ADDI = 4'h1,
        OP_LW   = 4'h2,
        OP_SW   = 4'h3,
        OP_BEQ  = 4'h4,
        OP_BNE  = 4'h5,
        OP_JAL  = 4'h6,
        OP_HALT = 4'hf
    } opcode_t;

    // alu function, low bits of the r-type function field
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_t;

    // rd = rs1 op rs2
    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [12:0] pad;
        alu_op_t     alu_op;
    } r_fmt_t;

    // addi, lw, sw, beq, bne, jal
    // stores and branches use rd as the second source register
    typedef struct packed {
        opcode_t            opcode;
        reg_idx_t           rd;
        reg_idx_t           rs1;
        logic signed [19:0] imm;
    } i_fmt_t;

    // same 32-bit word seen through either format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

`default_nettype wire

//--- source/execute.sv
// execute: ALU, branch resolution, load/store sequencing and writeback result select
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic               CLK,
    input  logic               nrst,
    input  logic               issue_valid,
    input  core_pkg::opcode_t  issue_op,
    input  core_pkg::alu_op_t  alu_op,
    input  core_pkg::reg_idx_t rd,
    input  core_pkg::word_t    rdat1,
    input  core_pkg::word_t    rdat2,
    input  core_pkg::word_t    imm,
    input  core_pkg::word_t    issue_pc,
    input  logic               dhit,
    input  core_pkg::word_t    dmem_load,
    output logic               dmem_ren,
    output logic               dmem_wen,
    output core_pkg::word_t    dmem_addr,
    output core_pkg::word_t    dmem_store,
    output logic               ex_busy,
    output logic               redirect,
    output core_pkg::word_t    redirect_pc,
    output logic               wb_en,
    output core_pkg::reg_idx_t wb_sel,
    output core_pkg::word_t    wb_data
);
    import core_pkg::*;

    word_t    alu_b;
    word_t    alu_y;
    word_t    link;
    logic     is_mem;
    logic     mem_start;
    logic     ren_q;
    logic     wen_q;
    word_t    addr_q;
    word_t    store_q;
    reg_idx_t load_rd_q;
    logic     load_done;

    // addi, lw and sw take the immediate as second operand
    assign alu_b = (issue_op == OP_ALU) ? rdat2 : imm;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_y = rdat1 - alu_b;
            ALU_AND: alu_y = rdat1 & alu_b;
            ALU_OR:  alu_y = rdat1 | alu_b;
            ALU_XOR: alu_y = rdat1 ^ alu_b;
            ALU_SLT: alu_y = {31'b0, $signed(rdat1) < $signed(alu_b)};
            default: alu_y = rdat1 + alu_b;
        endcase
    end

    // not-taken prediction, so any taken branch or jal is a miss
    assign redirect    = issue_valid && ((issue_op == OP_BEQ && rdat1 == rdat2) ||
                                         (issue_op == OP_BNE && rdat1 != rdat2) ||
                                         (issue_op == OP_JAL));
    assign redirect_pc = issue_pc + imm;
    assign link        = issue_pc + INSTR_BYTES;

    assign is_mem    = issue_op == OP_LW || issue_op == OP_SW;
    assign mem_start = issue_valid && is_mem;
    assign load_done = ren_q && dhit;
    assign ex_busy   = mem_start || ((ren_q || wen_q) && !dhit);

    assign dmem_ren   = ren_q;
    assign dmem_wen   = wen_q;
    assign dmem_addr  = addr_q;
    assign dmem_store = store_q;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            ren_q <= 1'b0;
            wen_q <= 1'b0;
        end else if (mem_start) begin
            ren_q <= issue_op == OP_LW;
            wen_q <= issue_op == OP_SW;
        end else if (dhit) begin
            ren_q <= 1'b0;
            wen_q <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (mem_start) begin
            addr_q    <= alu_y;
            store_q   <= rdat2;
            load_rd_q <= rd;
        end
    end

    // a load return never meets an issuing alu op
    always_comb begin
        wb_en   = 1'b0;
        wb_sel  = rd;
        wb_data = alu_y;
        if (load_done) begin
            wb_en   = 1'b1;
            wb_sel  = load_rd_q;
            wb_data = dmem_load;
        end else if (issue_valid && issue_op == OP_JAL) begin
            wb_en   = 1'b1;
            wb_data = link;
        end else if (issue_valid && (issue_op == OP_ALU || issue_op == OP_ADDI)) begin
            wb_en   = 1'b1;
        end
    end

    a_mem_exclusive: assert property (@(posedge CLK) disable iff (!nrst)
        !(dmem_ren && dmem_wen));

    a_mem_req_stable: assert property (@(posedge CLK) disable iff (!nrst)
        (dmem_ren || dmem_wen) && !dhit |=> $stable(dmem_addr) && $stable(dmem_store));

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
// fetch stage: program counter, instruction memory request, redirect and freeze handling
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter core_pkg::word_t RESET_PC = '0
) (
    input  logic            CLK,
    input  logic            nrst,
    input  logic            ihit,
    input  core_pkg::word_t imem_load,
    input  logic            freeze,
    input  logic            redirect,
    input  core_pkg::word_t redirect_pc,
    output logic            imem_ren,
    output core_pkg::word_t imem_addr,
    output core_pkg::word_t instr,
    output core_pkg::word_t pc,
    output logic            fetch_valid
);
    import core_pkg::*;

    word_t pc_q;
    word_t addr_q;
    logic  ren_q;
    logic  drop_q;
    logic  hit;
    logic  start;
    logic  buf_valid;
    word_t buf_instr;
    word_t buf_pc;

    assign hit         = ihit && ren_q;
    assign fetch_valid = buf_valid && !freeze;
    // one request at a time, buffer drains in the same cycle when not frozen
    assign start       = !redirect && !freeze && !ren_q;

    assign imem_ren  = ren_q;
    assign imem_addr = addr_q;
    assign instr     = buf_instr;
    assign pc        = buf_pc;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc_q      <= RESET_PC;
            addr_q    <= RESET_PC;
            ren_q     <= 1'b0;
            drop_q    <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            if (redirect) begin
                pc_q <= redirect_pc;
            end else if (hit && !drop_q) begin
                pc_q <= pc_q + INSTR_BYTES;
            end

            if (start) begin
                ren_q  <= 1'b1;
                addr_q <= pc_q;
            end else if (hit) begin
                ren_q <= 1'b0;
            end

            // wrong-path word still in flight, let it land and forget it
            if (redirect && ren_q && !ihit) begin
                drop_q <= 1'b1;
            end else if (hit) begin
                drop_q <= 1'b0;
            end

            if (redirect) begin
                buf_valid <= 1'b0;
            end else if (hit && !drop_q) begin
                buf_valid <= 1'b1;
            end else if (fetch_valid) begin
                buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (hit && !drop_q && !redirect) begin
            buf_instr <= imem_load;
            buf_pc    <= addr_q;
        end
    end

    a_pc_aligned: assert property (@(posedge CLK) disable iff (!nrst)
        pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- source/sc_datapath.sv
// top level: fetch, scoreboard and execute with the fetch and writeback latches
`timescale 1ns/1ps
`default_nettype none

module sc_datapath #(
    parameter core_pkg::word_t RESET_PC = '0
) (
    input  logic            CLK,
    input  logic            nrst,
    output logic            imem_ren,
    output core_pkg::word_t imem_addr,
    input  logic            ihit,
    input  core_pkg::word_t imem_load,
    output logic            dmem_ren,
    output logic            dmem_wen,
    output core_pkg::word_t dmem_addr,
    output core_pkg::word_t dmem_store,
    input  logic            dhit,
    input  core_pkg::word_t dmem_load,
    output logic            halt
);
    import core_pkg::*;

    word_t    f_instr;
    word_t    f_pc;
    logic     f_valid;

    // fetch latch
    logic     fl_valid;
    word_t    fl_instr;
    word_t    fl_pc;

    logic     freeze;
    logic     issue_valid;
    opcode_t  issue_op;
    alu_op_t  alu_op;
    reg_idx_t rd;
    word_t    rdat1;
    word_t    rdat2;
    word_t    imm;
    word_t    issue_pc;

    logic     ex_busy;
    logic     redirect;
    word_t    redirect_pc;
    logic     ex_wb_en;
    reg_idx_t ex_wb_sel;
    word_t    ex_wb_data;

    // writeback latch
    logic     wb_en_q;
    reg_idx_t wb_sel_q;
    word_t    wb_data_q;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .CLK         (CLK),
        .nrst        (nrst),
        .ihit        (ihit),
        .imem_load   (imem_load),
        .freeze      (freeze),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_ren    (imem_ren),
        .imem_addr   (imem_addr),
        .instr       (f_instr),
        .pc          (f_pc),
        .fetch_valid (f_valid)
    );

    scoreboard u_sb (
        .CLK         (CLK),
        .nrst        (nrst),
        .fetch_instr (fl_instr),
        .fetch_valid (fl_valid),
        .fetch_pc    (fl_pc),
        .redirect    (redirect),
        .ex_busy     (ex_busy),
        .wb_en       (wb_en_q),
        .wb_sel      (wb_sel_q),
        .wb_data     (wb_data_q),
        .freeze      (freeze),
        .halt        (halt),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .alu_op      (alu_op),
        .rd          (rd),
        .rdat1       (rdat1),
        .rdat2       (rdat2),
        .imm         (imm),
        .issue_pc    (issue_pc)
    );

    execute u_ex (
        .CLK         (CLK),
        .nrst        (nrst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .alu_op      (alu_op),
        .rd          (rd),
        .rdat1       (rdat1),
        .rdat2       (rdat2),
        .imm         (imm),
        .issue_pc    (issue_pc),
        .dhit        (dhit),
        .dmem_load   (dmem_load),
        .dmem_ren    (dmem_ren),
        .dmem_wen    (dmem_wen),
        .dmem_addr   (dmem_addr),
        .dmem_store  (dmem_store),
        .ex_busy     (ex_busy),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_en       (ex_wb_en),
        .wb_sel      (ex_wb_sel),
        .wb_data     (ex_wb_data)
    );

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            fl_valid <= 1'b0;
            wb_en_q  <= 1'b0;
        end else begin
            // flush on a miss, hold under freeze
            if (redirect) begin
                fl_valid <= 1'b0;
            end else if (!freeze) begin
                fl_valid <= f_valid;
            end
            // jal link must survive its own redirect
            wb_en_q <= ex_wb_en;
        end
    end

    always_ff @(posedge CLK) begin
        if (!freeze) begin
            fl_instr <= f_instr;
            fl_pc    <= f_pc;
        end
        wb_sel_q  <= ex_wb_sel;
        wb_data_q <= ex_wb_data;
    end

endmodule

`default_nettype wire

//--- source/scoreboard.sv
// scoreboard: decode, register file, busy bits, hazard stall and issue register
`timescale 1ns/1ps
`default_nettype none

module scoreboard (
    input  logic               CLK,
    input  logic               nrst,
    input  core_pkg::word_t    fetch_instr,
    input  logic               fetch_valid,
    input  core_pkg::word_t    fetch_pc,
    input  logic               redirect,
    input  logic               ex_busy,
    input  logic               wb_en,
    input  core_pkg::reg_idx_t wb_sel,
    input  core_pkg::word_t    wb_data,
    output logic               freeze,
    output logic               halt,
    output logic               issue_valid,
    output core_pkg::opcode_t  issue_op,
    output core_pkg::alu_op_t  alu_op,
    output core_pkg::reg_idx_t rd,
    output core_pkg::word_t    rdat1,
    output core_pkg::word_t    rdat2,
    output core_pkg::word_t    imm,
    output core_pkg::word_t    issue_pc
);
    import core_pkg::*;

    localparam logic [NUM_REGS-1:0] ONE_HOT = {{(NUM_REGS-1){1'b0}}, 1'b1};

    instr_u              dec;
    opcode_t             op;
    reg_idx_t            src1;
    reg_idx_t            src2;
    reg_idx_t            dst;
    logic                use1;
    logic                use2;
    logic                writes;
    word_t               val1;
    word_t               val2;
    logic [NUM_REGS-1:0] busy_q;
    logic [NUM_REGS-1:0] wb_mask;
    logic [NUM_REGS-1:0] busy_now;
    logic                hazard;
    logic                issue_go;
    logic                halt_q;
    word_t               regs [NUM_REGS];

    assign dec  = fetch_instr;
    assign op   = dec.r.opcode;
    assign src1 = dec.r.rs1;
    assign dst  = dec.r.rd;
    // second source sits in rs2 for r-type, in the rd slot otherwise
    assign src2 = (op == OP_ALU) ? dec.r.rs2 : dec.i.rd;

    always_comb begin
        use1   = 1'b0;
        use2   = 1'b0;
        writes = 1'b0;
        case (op)
            OP_ALU:         begin use1 = 1'b1; use2 = 1'b1; writes = 1'b1; end
            OP_ADDI, OP_LW: begin use1 = 1'b1; writes = 1'b1; end
            OP_SW, OP_BEQ,
            OP_BNE:         begin use1 = 1'b1; use2 = 1'b1; end
            OP_JAL:         writes = 1'b1;
            default:        ;
        endcase
        if (dst == REG_ZERO) begin
            writes = 1'b0;
        end
    end

    // register read with same-cycle writeback forwarding
    assign val1 = (src1 == REG_ZERO) ? '0 :
                  (wb_en && wb_sel == src1) ? wb_data : regs[src1];
    assign val2 = (src2 == REG_ZERO) ? '0 :
                  (wb_en && wb_sel == src2) ? wb_data : regs[src2];

    assign wb_mask  = wb_en ? (ONE_HOT << wb_sel) : '0;
    assign busy_now = busy_q & ~wb_mask;

    // raw on either source, waw on the destination
    assign hazard = fetch_valid && ((use1 && busy_now[src1]) ||
                                    (use2 && busy_now[src2]) ||
                                    (writes && busy_now[dst]));

    assign freeze   = hazard || ex_busy || halt_q;
    assign issue_go = fetch_valid && !freeze && !redirect;
    assign halt     = halt_q;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy_q      <= '0;
            issue_valid <= 1'b0;
            halt_q      <= 1'b0;
            regs        <= '{default: '0};
        end else begin
            busy_q      <= busy_now | ((issue_go && writes) ? (ONE_HOT << dst) : '0);
            issue_valid <= issue_go;
            if (issue_go && op == OP_HALT) begin
                halt_q <= 1'b1;
            end
            if (wb_en && wb_sel != REG_ZERO) begin
                regs[wb_sel] <= wb_data;
            end
        end
    end

    // issue register payload
    always_ff @(posedge CLK) begin
        if (issue_go) begin
            issue_op <= op;
            alu_op   <= (op == OP_ALU) ? dec.r.alu_op : ALU_ADD;
            rd       <= writes ? dst : REG_ZERO;
            rdat1    <= val1;
            rdat2    <= val2;
            imm      <= {{12{dec.i.imm[19]}}, dec.i.imm};
            issue_pc <= fetch_pc;
        end
    end

    // a frozen instruction is not consumed and waits in the fetch latch
    a_frozen_held: assert property (@(posedge CLK) disable iff (!nrst)
        freeze && fetch_valid && !redirect |=> fetch_valid && $stable(fetch_instr));

    a_r0_not_busy: assert property (@(posedge CLK) disable iff (!nrst)
        !busy_q[0]);

endmodule

`default_nettype wire

//--- src.f
+incdir+bench
source/core_pkg.sv
source/fetch_stage.sv
source/scoreboard.sv
source/execute.sv
source/sc_datapath.sv
bench/tb_sc_datapath.sv
